//--- common/decodePkg.sv
`default_nettype none

package decodePkg;

	// ========================================
	// Sizes
	// ========================================

	// Instructions handled per fetch bundle
	localparam int Lanes = 2;

	localparam int InstrWidth = 36;
	// Address distance between neighbouring slots of a bundle
	localparam int InstrBytes = 8;
	localparam int ValueSize = 64;
	localparam int AddrWidth = 32;
	localparam int RegIdxWidth = 6;
	// JAL can only link into the low registers
	localparam int LinkRegBits = 2;

	// ========================================
	// Instruction fields
	// ========================================

	localparam int OpcodeLsb = 0;
	localparam int OpcodeMsb = 7;
	localparam int RtLsb = 8;
	localparam int RtMsb = 13;
	localparam int RaLsb = 14;
	localparam int RaMsb = 19;
	localparam int RbLsb = 20;
	localparam int RbMsb = 25;
	localparam int FuncLsb = 30;
	localparam int FuncMsb = 35;

	// The 16-bit immediate overlaps Rb and func
	localparam int ImmLsb = 20;
	localparam int ImmMsb = 35;

	// Split displacement of branches and stores, low part sits in the Rt field
	localparam int DispHiLsb = 26;
	localparam int DispHiMsb = 35;
	localparam int DispLoLsb = 8;
	localparam int DispLoMsb = 13;

	// Load displacement and JAL target offset
	localparam int LdDispLsb = 20;
	localparam int LdDispMsb = 31;
	localparam int JalDispLsb = 10;
	localparam int JalDispMsb = 35;

	// ========================================
	// Types
	// ========================================

	typedef logic [InstrWidth-1:0] instrT;
	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [RegIdxWidth-1:0] regIdxT;
	typedef logic [ValueSize-1:0] valueT;
	typedef logic [$clog2(Lanes+1)-1:0] laneCountT;

	typedef enum logic [7:0] {
		BRK   = 8'h00,
		R1    = 8'h01,
		R2    = 8'h02,
		ADDI  = 8'h04,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTI  = 8'h0C,
		SLTUI = 8'h0D,
		MULI  = 8'h10,
		MULUI = 8'h11,
		JAL   = 8'h40,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BLTU  = 8'h4B,
		LDX   = 8'h60,
		STX   = 8'h70,
		NOP   = 8'hF1
	} opcodeE;

	// R1 uses the first four codes, R2 the rest
	typedef enum logic [5:0] {
		ABS   = 6'h00,
		NOT   = 6'h01,
		CTLZ  = 6'h02,
		CTPOP = 6'h03,
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		SLL   = 6'h10,
		SRL   = 6'h11,
		SLLI  = 6'h12,
		SLT   = 6'h18,
		SLTU  = 6'h19,
		MUL   = 6'h20,
		MULU  = 6'h21,
		DIV   = 6'h24,
		DIVU  = 6'h25
	} funcE;

endpackage

`default_nettype wire

//--- decode/fetchSplitter.sv
`default_nettype none
`timescale 1ns/1ns

module fetchSplitter (
	input  wire                                        clk,
	input  wire                                        rstN,
	input  wire                                        bundleValid,
	input  decodePkg::addrT                            bundlePc,
	input  decodePkg::instrT [decodePkg::Lanes-1:0]    bundleWords,
	input  decodePkg::laneCountT                       bundleCount,
	output logic                                       bundleSeen,
	output logic [decodePkg::Lanes-1:0]                slotValid,
	output decodePkg::instrT [decodePkg::Lanes-1:0]    slotInstr,
	output decodePkg::addrT [decodePkg::Lanes-1:0]     slotPc
);

	import decodePkg::*;

	// A bundle strobe is carried along even when no slot is filled
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bundleSeen <= 1'b0;
			slotValid <= '0;
		end else begin
			bundleSeen <= bundleValid;
			for (int k = 0; k < Lanes; k++) begin
				slotValid[k] <= bundleValid && (k < int'(bundleCount));
			end
		end
	end

	// Slot payload is only loaded on a strobe
	always_ff @(posedge clk) begin
		if (bundleValid) begin
			for (int k = 0; k < Lanes; k++) begin
				slotInstr[k] <= bundleWords[k];
				slotPc[k] <= bundlePc + addrT'(k * InstrBytes);
			end
		end
	end

	// The fetch unit never claims more slots than a bundle has
	assertCountRange: assert property (
		@(posedge clk) disable iff (!rstN)
		bundleValid |-> (int'(bundleCount) <= Lanes)
	);

endmodule

`default_nettype wire

//--- decode/laneDecoder.sv
`default_nettype none
`timescale 1ns/1ns

module laneDecoder (
	input  wire               clk,
	input  wire               rstN,
	input  wire               slotValid,
	input  decodePkg::instrT  slotInstr,
	input  decodePkg::addrT   slotPc,
	output logic              decValid,
	output logic              ui,
	output logic              rfwr,
	output decodePkg::regIdxT rt,
	output decodePkg::regIdxT ra,
	output decodePkg::regIdxT rb,
	output logic              needRa,
	output logic              needRb,
	output logic              isSigned,
	output logic              branch,
	output logic              memLoad,
	output logic              memStore,
	output logic              mc,
	output decodePkg::valueT  imm,
	output decodePkg::addrT   pc
);

	import decodePkg::*;

	opcodeE op;
	funcE   func;
	regIdxT rtField;
	logic [ImmMsb-ImmLsb:0] imm16;
	valueT  immSext;
	valueT  immZext;
	valueT  immOnes;
	valueT  ldDisp;
	valueT  splitDisp;
	valueT  jalDisp;
	valueT  shiftAmt;

	logic   nUi, nRfwr, nNeedRa, nNeedRb, nIsSigned;
	logic   nBranch, nMemLoad, nMemStore, nMc;
	regIdxT nRt;
	valueT  nImm;

	assign op = opcodeE'(slotInstr[OpcodeMsb:OpcodeLsb]);
	assign func = funcE'(slotInstr[FuncMsb:FuncLsb]);
	assign rtField = slotInstr[RtMsb:RtLsb];
	assign imm16 = slotInstr[ImmMsb:ImmLsb];

	// ========================================
	// Immediate extension
	// ========================================
	assign immSext = {{(ValueSize-$bits(imm16)){imm16[$bits(imm16)-1]}}, imm16};
	assign immZext = {{(ValueSize-$bits(imm16)){1'b0}}, imm16};
	// ANDI keeps the upper bits of the source intact
	assign immOnes = {{(ValueSize-$bits(imm16)){1'b1}}, imm16};
	assign ldDisp = {{(ValueSize-(LdDispMsb-LdDispLsb+1)){slotInstr[LdDispMsb]}},
		slotInstr[LdDispMsb:LdDispLsb]};
	assign splitDisp = {{(ValueSize-(DispHiMsb-DispHiLsb+1)-(DispLoMsb-DispLoLsb+1))
		{slotInstr[DispHiMsb]}}, slotInstr[DispHiMsb:DispHiLsb], slotInstr[DispLoMsb:DispLoLsb]};
	assign jalDisp = {{(ValueSize-(JalDispMsb-JalDispLsb+1)){slotInstr[JalDispMsb]}},
		slotInstr[JalDispMsb:JalDispLsb]};
	assign shiftAmt = {{(ValueSize-RegIdxWidth){1'b0}}, slotInstr[RbMsb:RbLsb]};

	// ========================================
	// Decode
	// ========================================
	always_comb begin
		nUi = 1'b1;
		nRfwr = 1'b0;
		nRt = '0;
		nNeedRa = 1'b1;
		nNeedRb = 1'b0;
		nIsSigned = 1'b1;
		nBranch = 1'b0;
		nMemLoad = 1'b0;
		nMemStore = 1'b0;
		nMc = 1'b0;
		nImm = '0;
		case (op)
			NOP, BRK: nUi = 1'b0;
			R1: begin
				case (func)
					ABS, NOT, CTLZ, CTPOP: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
					end
					default: ;
				endcase
			end
			R2: begin
				nNeedRb = 1'b1;
				case (func)
					ADD, SUB, AND, OR, XOR, SLL, SRL, SLT: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
					end
					SLTU: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
						nIsSigned = 1'b0;
					end
					// Shift amount is encoded in place of Rb
					SLLI: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
						nImm = shiftAmt;
					end
					MUL, DIV: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
						nMc = 1'b1;
					end
					MULU, DIVU: begin
						nUi = 1'b0;
						nRfwr = 1'b1;
						nMc = 1'b1;
						nIsSigned = 1'b0;
					end
					default: ;
				endcase
			end
			ADDI, SLTI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immSext;
			end
			ANDI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immOnes;
			end
			ORI, XORI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immZext;
			end
			SLTUI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immZext;
				nIsSigned = 1'b0;
			end
			MULI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immSext;
				nMc = 1'b1;
			end
			MULUI: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = immZext;
				nMc = 1'b1;
				nIsSigned = 1'b0;
			end
			JAL: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nNeedRa = 1'b0;
				nImm = jalDisp;
				nBranch = 1'b1;
				nMc = 1'b1;
			end
			BEQ, BNE, BLT, BLTU: begin
				nUi = 1'b0;
				nNeedRb = 1'b1;
				nImm = splitDisp;
				nBranch = 1'b1;
				nMc = 1'b1;
				nIsSigned = (op != BLTU);
			end
			LDX: begin
				nUi = 1'b0;
				nRfwr = 1'b1;
				nImm = ldDisp;
				nMemLoad = 1'b1;
				nMc = 1'b1;
			end
			STX: begin
				nUi = 1'b0;
				nNeedRb = 1'b1;
				nImm = splitDisp;
				nMemStore = 1'b1;
				nMc = 1'b1;
			end
			default: ;
		endcase
		// Only writers name a target, JAL links to a low register
		if (nRfwr) begin
			nRt = (op == JAL) ? regIdxT'(rtField[LinkRegBits-1:0]) : rtField;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= slotValid;
		end
	end

	always_ff @(posedge clk) begin
		ui <= nUi;
		rfwr <= nRfwr;
		rt <= nRt;
		ra <= slotInstr[RaMsb:RaLsb];
		rb <= slotInstr[RbMsb:RbLsb];
		needRa <= nNeedRa;
		needRb <= nNeedRb;
		isSigned <= nIsSigned;
		branch <= nBranch;
		memLoad <= nMemLoad;
		memStore <= nMemStore;
		mc <= nMc;
		imm <= nImm;
		pc <= slotPc;
	end

	// A store has no register result
	assertNoStoreWrite: assert property (
		@(posedge clk) disable iff (!rstN)
		decValid |-> !(rfwr && memStore)
	);

endmodule

`default_nettype wire

//--- decode/bundleCollector.sv
`default_nettype none
`timescale 1ns/1ns

module bundleCollector (
	input  wire                                      clk,
	input  wire                                      rstN,
	input  wire                                      bundleSeen,
	input  wire  [decodePkg::Lanes-1:0]              decValid,
	input  wire  [decodePkg::Lanes-1:0]              decUi,
	input  wire  [decodePkg::Lanes-1:0]              decRfwr,
	input  decodePkg::regIdxT [decodePkg::Lanes-1:0] decRt,
	input  decodePkg::regIdxT [decodePkg::Lanes-1:0] decRa,
	input  decodePkg::regIdxT [decodePkg::Lanes-1:0] decRb,
	input  wire  [decodePkg::Lanes-1:0]              decNeedRa,
	input  wire  [decodePkg::Lanes-1:0]              decNeedRb,
	input  wire  [decodePkg::Lanes-1:0]              decIsSigned,
	input  wire  [decodePkg::Lanes-1:0]              decBranch,
	input  wire  [decodePkg::Lanes-1:0]              decMemLoad,
	input  wire  [decodePkg::Lanes-1:0]              decMemStore,
	input  wire  [decodePkg::Lanes-1:0]              decMc,
	input  decodePkg::valueT [decodePkg::Lanes-1:0]  decImm,
	input  decodePkg::addrT [decodePkg::Lanes-1:0]   decPc,
	output logic                                     outValid,
	output logic [decodePkg::Lanes-1:0]              laneValid,
	output logic [decodePkg::Lanes-1:0]              hazard,
	output logic [decodePkg::Lanes-1:0]              ui,
	output logic [decodePkg::Lanes-1:0]              rfwr,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] rt,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] ra,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] rb,
	output logic [decodePkg::Lanes-1:0]              needRa,
	output logic [decodePkg::Lanes-1:0]              needRb,
	output logic [decodePkg::Lanes-1:0]              isSigned,
	output logic [decodePkg::Lanes-1:0]              branch,
	output logic [decodePkg::Lanes-1:0]              memLoad,
	output logic [decodePkg::Lanes-1:0]              memStore,
	output logic [decodePkg::Lanes-1:0]              mc,
	output decodePkg::valueT [decodePkg::Lanes-1:0]  imm,
	output decodePkg::addrT [decodePkg::Lanes-1:0]   pc,
	output logic                                     illegalValid,
	output decodePkg::addrT                          illegalPc
);

	import decodePkg::*;

	// Bundle strobe aligned with the decoder outputs
	logic decBundle;
	logic [Lanes-1:0] nLaneValid;
	logic [Lanes-1:0] nHazard;
	logic nIllegal;
	addrT nIllegalPc;

	always_comb begin
		logic cut;
		cut = 1'b0;
		nIllegal = 1'b0;
		nIllegalPc = decPc[0];
		nLaneValid = '0;
		nHazard = '0;
		for (int k = 0; k < Lanes; k++) begin
			nLaneValid[k] = decValid[k] && !decUi[k] && !cut;
			// Compare against older lanes that survive the cut
			for (int j = 0; j < k; j++) begin
				if (nLaneValid[j] && decRfwr[j] && decRt[j] != '0 &&
					((decNeedRa[k] && decRa[k] == decRt[j]) ||
					(decNeedRb[k] && decRb[k] == decRt[j]))) begin
					nHazard[k] = 1'b1;
				end
			end
			if (decValid[k] && decUi[k] && !nIllegal) begin
				nIllegal = 1'b1;
				nIllegalPc = decPc[k];
			end
			// Nothing after a control transfer or an unknown op goes out
			if (decValid[k] && (decBranch[k] || decUi[k])) begin
				cut = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decBundle <= 1'b0;
			outValid <= 1'b0;
			laneValid <= '0;
			hazard <= '0;
			illegalValid <= 1'b0;
		end else begin
			decBundle <= bundleSeen;
			outValid <= decBundle;
			laneValid <= nLaneValid;
			hazard <= nHazard;
			illegalValid <= decBundle && nIllegal;
		end
	end

	always_ff @(posedge clk) begin
		ui <= decUi;
		rfwr <= decRfwr;
		rt <= decRt;
		ra <= decRa;
		rb <= decRb;
		needRa <= decNeedRa;
		needRb <= decNeedRb;
		isSigned <= decIsSigned;
		branch <= decBranch;
		memLoad <= decMemLoad;
		memStore <= decMemStore;
		mc <= decMc;
		imm <= decImm;
		pc <= decPc;
		illegalPc <= nIllegalPc;
	end

	// The oldest lane has nothing to depend on
	assertLaneZeroClean: assert property (
		@(posedge clk) disable iff (!rstN)
		!hazard[0]
	);

	assertIllegalInBundle: assert property (
		@(posedge clk) disable iff (!rstN)
		illegalValid |-> outValid
	);

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`default_nettype none
`timescale 1ns/1ns

module decodeStage (
	input  wire                                      clk,
	input  wire                                      rstN,
	input  wire                                      bundleValid,
	input  decodePkg::addrT                          bundlePc,
	input  decodePkg::instrT [decodePkg::Lanes-1:0]  bundleWords,
	input  decodePkg::laneCountT                     bundleCount,
	output logic                                     outValid,
	output logic [decodePkg::Lanes-1:0]              laneValid,
	output logic [decodePkg::Lanes-1:0]              hazard,
	output logic [decodePkg::Lanes-1:0]              ui,
	output logic [decodePkg::Lanes-1:0]              rfwr,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] rt,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] ra,
	output decodePkg::regIdxT [decodePkg::Lanes-1:0] rb,
	output logic [decodePkg::Lanes-1:0]              needRa,
	output logic [decodePkg::Lanes-1:0]              needRb,
	output logic [decodePkg::Lanes-1:0]              isSigned,
	output logic [decodePkg::Lanes-1:0]              branch,
	output logic [decodePkg::Lanes-1:0]              memLoad,
	output logic [decodePkg::Lanes-1:0]              memStore,
	output logic [decodePkg::Lanes-1:0]              mc,
	output decodePkg::valueT [decodePkg::Lanes-1:0]  imm,
	output decodePkg::addrT [decodePkg::Lanes-1:0]   pc,
	output logic                                     illegalValid,
	output decodePkg::addrT                          illegalPc
);

	import decodePkg::*;

	logic bundleSeen;
	logic [Lanes-1:0] slotValid;
	instrT [Lanes-1:0] slotInstr;
	addrT [Lanes-1:0] slotPc;

	logic [Lanes-1:0] decValid, decUi, decRfwr, decNeedRa, decNeedRb;
	logic [Lanes-1:0] decIsSigned, decBranch, decMemLoad, decMemStore, decMc;
	regIdxT [Lanes-1:0] decRt, decRa, decRb;
	valueT [Lanes-1:0] decImm;
	addrT [Lanes-1:0] decPc;

	fetchSplitter i_fetchSplitter (
		.clk(clk), .rstN(rstN),
		.bundleValid(bundleValid), .bundlePc(bundlePc),
		.bundleWords(bundleWords), .bundleCount(bundleCount),
		.bundleSeen(bundleSeen), .slotValid(slotValid),
		.slotInstr(slotInstr), .slotPc(slotPc)
	);

	// ========================================
	// One decoder per slot
	// ========================================
	for (genvar k = 0; k < Lanes; k++) begin : genLane
		laneDecoder i_laneDecoder (
			.clk(clk), .rstN(rstN),
			.slotValid(slotValid[k]), .slotInstr(slotInstr[k]), .slotPc(slotPc[k]),
			.decValid(decValid[k]), .ui(decUi[k]), .rfwr(decRfwr[k]),
			.rt(decRt[k]), .ra(decRa[k]), .rb(decRb[k]),
			.needRa(decNeedRa[k]), .needRb(decNeedRb[k]), .isSigned(decIsSigned[k]),
			.branch(decBranch[k]), .memLoad(decMemLoad[k]), .memStore(decMemStore[k]),
			.mc(decMc[k]), .imm(decImm[k]), .pc(decPc[k])
		);
	end

	bundleCollector i_bundleCollector (
		.clk(clk), .rstN(rstN), .bundleSeen(bundleSeen),
		.decValid(decValid), .decUi(decUi), .decRfwr(decRfwr),
		.decRt(decRt), .decRa(decRa), .decRb(decRb),
		.decNeedRa(decNeedRa), .decNeedRb(decNeedRb), .decIsSigned(decIsSigned),
		.decBranch(decBranch), .decMemLoad(decMemLoad), .decMemStore(decMemStore),
		.decMc(decMc), .decImm(decImm), .decPc(decPc),
		.outValid(outValid), .laneValid(laneValid), .hazard(hazard),
		.ui(ui), .rfwr(rfwr), .rt(rt), .ra(ra), .rb(rb),
		.needRa(needRa), .needRb(needRb), .isSigned(isSigned),
		.branch(branch), .memLoad(memLoad), .memStore(memStore),
		.mc(mc), .imm(imm), .pc(pc),
		.illegalValid(illegalValid), .illegalPc(illegalPc)
	);

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`default_nettype none
`timescale 1ns/1ns

module clockGen (
	output logic clk,
	output logic rstN
);

	// 100 ns clock period
	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// Reset is held for 8 rising edges and released just after the last one
	initial begin
		rstN = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/decodeStageTb.sv
`default_nettype none
`timescale 1ns/1ns

module decodeStageTb;

	import decodePkg::*;

	logic clk;
	logic rstN;
	logic bundleValid;
	addrT bundlePc;
	instrT [Lanes-1:0] bundleWords;
	laneCountT bundleCount;
	logic outValid;
	logic illegalValid;
	addrT illegalPc;
	logic [Lanes-1:0] laneValid, hazard, ui, rfwr, needRa, needRb;
	logic [Lanes-1:0] isSigned, branch, memLoad, memStore, mc;
	regIdxT [Lanes-1:0] rt, ra, rb;
	valueT [Lanes-1:0] imm;
	addrT [Lanes-1:0] pc;

	int seed = 32'h78368a58;
	int cycleCount = 0;
	int errCount = 0;
	int testErrStart = 0;
	int passCount = 0;
	int failCount = 0;
	// Cycle of each strobe that still waits for its outValid
	int strobeCycles[$];

	clockGen i_clockGen (.clk(clk), .rstN(rstN));

	decodeStage i_decodeStage (
		.clk(clk), .rstN(rstN), .bundleValid(bundleValid), .bundlePc(bundlePc),
		.bundleWords(bundleWords), .bundleCount(bundleCount),
		.outValid(outValid), .laneValid(laneValid), .hazard(hazard), .ui(ui),
		.rfwr(rfwr), .rt(rt), .ra(ra), .rb(rb), .needRa(needRa), .needRb(needRb),
		.isSigned(isSigned), .branch(branch), .memLoad(memLoad), .memStore(memStore),
		.mc(mc), .imm(imm), .pc(pc), .illegalValid(illegalValid), .illegalPc(illegalPc)
	);

	// All tests together take well under 300 cycles
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= 2000) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ========================================
	// Instruction encoding
	// ========================================

	function automatic instrT regWord(input logic [7:0] op, input logic [5:0] fn,
		input regIdxT rtIdx, input regIdxT raIdx, input regIdxT rbIdx);
		return {fn, 4'b0, rbIdx, raIdx, rtIdx, op};
	endfunction

	function automatic instrT immWord(input logic [7:0] op, input regIdxT rtIdx,
		input regIdxT raIdx, input logic [15:0] imm16);
		return {imm16, raIdx, rtIdx, op};
	endfunction

	// High ten displacement bits on top, low six in the Rt field
	function automatic instrT splitWord(input logic [7:0] op, input regIdxT raIdx,
		input regIdxT rbIdx, input logic [15:0] disp);
		return {disp[15:6], rbIdx, raIdx, disp[5:0], op};
	endfunction

	function automatic regIdxT randReg();
		return regIdxT'($random(seed));
	endfunction

	// ========================================
	// Driving and checking
	// ========================================

	task automatic checkField(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			errCount++;
		end
	endtask

	task automatic sendBundle(input addrT pcVal, input instrT w0, input instrT w1,
		input laneCountT count);
		@(posedge clk);
		#1;
		bundleValid = 1'b1;
		bundlePc = pcVal;
		bundleWords[0] = w0;
		bundleWords[1] = w1;
		bundleCount = count;
		strobeCycles.push_back(cycleCount);
	endtask

	// Ends any strobe and waits for the oldest bundle to come out
	task automatic waitOut();
		int waited;
		int strobe;
		waited = 0;
		@(posedge clk);
		#1;
		bundleValid = 1'b0;
		while (!outValid && waited < 10) begin
			@(posedge clk);
			#1;
			waited++;
		end
		strobe = strobeCycles.pop_front();
		assert (outValid) else begin
			$display("outValid did not rise within 10 cycles of the bundle strobe");
			errCount++;
		end
		checkField("latency", 3, cycleCount - strobe);
	endtask

	task automatic checkWriter(input int lane, input regIdxT rtIdx, input regIdxT raIdx,
		input regIdxT rbIdx, input logic needRbExp, input logic signedExp, input logic mcExp);
		checkField($sformatf("laneValid[%0d]", lane), 1, laneValid[lane]);
		checkField($sformatf("ui[%0d]", lane), 0, ui[lane]);
		checkField($sformatf("rfwr[%0d]", lane), 1, rfwr[lane]);
		checkField($sformatf("rt[%0d]", lane), rtIdx, rt[lane]);
		checkField($sformatf("ra[%0d]", lane), raIdx, ra[lane]);
		checkField($sformatf("rb[%0d]", lane), rbIdx, rb[lane]);
		checkField($sformatf("needRa[%0d]", lane), 1, needRa[lane]);
		checkField($sformatf("needRb[%0d]", lane), needRbExp, needRb[lane]);
		checkField($sformatf("isSigned[%0d]", lane), signedExp, isSigned[lane]);
		checkField($sformatf("mc[%0d]", lane), mcExp, mc[lane]);
	endtask

	task automatic checkKind(input int lane, input logic loadExp, input logic storeExp,
		input logic branchExp);
		checkField($sformatf("memLoad[%0d]", lane), loadExp, memLoad[lane]);
		checkField($sformatf("memStore[%0d]", lane), storeExp, memStore[lane]);
		checkField($sformatf("branch[%0d]", lane), branchExp, branch[lane]);
	endtask

	task automatic finishTest(input string name);
		if (errCount == testErrStart) begin
			passCount++;
			$display("Test %s: ok", name);
		end else begin
			failCount++;
			$display("Test %s: %0d errors", name, errCount - testErrStart);
		end
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic testRegOps();
		regIdxT r[12];
		testErrStart = errCount;
		checkField("outValid", 0, outValid);
		checkField("laneValid", 0, laneValid);
		checkField("illegalValid", 0, illegalValid);
		for (int i = 0; i < 12; i++) begin
			r[i] = randReg();
		end
		// Two bundles back to back come out on consecutive cycles
		sendBundle(32'h1000, regWord(R2, ADD, r[0], r[1], r[2]),
			regWord(R2, MUL, r[3], r[4], r[5]), 2);
		sendBundle(32'h1010, regWord(R2, SLTU, r[6], r[7], r[8]),
			regWord(R1, CTPOP, r[9], r[10], r[11]), 2);
		waitOut();
		checkWriter(0, r[0], r[1], r[2], 1, 1, 0);
		checkWriter(1, r[3], r[4], r[5], 1, 1, 1);
		waitOut();
		checkWriter(0, r[6], r[7], r[8], 1, 0, 0);
		checkWriter(1, r[9], r[10], r[11], 0, 1, 0);
		sendBundle(32'h1020, regWord(R1, NOT, r[1], r[2], r[3]), '0, 1);
		waitOut();
		checkWriter(0, r[1], r[2], r[3], 0, 1, 0);
		finishTest("register ops");
	endtask

	task automatic testImmediates();
		opcodeE ops[8];
		opcodeE op;
		logic [15:0] imm16;
		valueT expImm;
		regIdxT rtIdx;
		regIdxT raIdx;
		ops = '{ADDI, ANDI, ORI, XORI, SLTI, SLTUI, MULI, MULUI};
		testErrStart = errCount;
		// First pass with the immediate sign bit set, second with it clear
		for (int i = 0; i < 16; i++) begin
			op = ops[i % 8];
			imm16 = 16'($random(seed));
			imm16[15] = (i < 8);
			rtIdx = randReg();
			raIdx = randReg();
			case (op)
				ANDI: expImm = {48'hFFFF_FFFF_FFFF, imm16};
				ORI, XORI, SLTUI, MULUI: expImm = {48'h0, imm16};
				default: expImm = {{48{imm16[15]}}, imm16};
			endcase
			sendBundle(32'h2000 + 32'(i * 16), immWord(op, rtIdx, raIdx, imm16), '0, 1);
			waitOut();
			checkWriter(0, rtIdx, raIdx, imm16[5:0], 0, !(op inside {SLTUI, MULUI}),
				op inside {MULI, MULUI});
			checkField("imm[0]", expImm, imm[0]);
		end
		// The shift amount sits in the Rb field
		rtIdx = randReg();
		raIdx = randReg();
		imm16 = 16'($random(seed));
		sendBundle(32'h2200, regWord(R2, SLLI, rtIdx, raIdx, imm16[5:0]), '0, 1);
		waitOut();
		checkWriter(0, rtIdx, raIdx, imm16[5:0], 1, 1, 0);
		checkField("imm[0]", {58'h0, imm16[5:0]}, imm[0]);
		finishTest("immediates");
	endtask

	task automatic testMemControl();
		addrT pcBase;
		logic [15:0] disp;
		logic [11:0] ldDisp;
		logic [25:0] jalDisp;
		logic [1:0] link;
		regIdxT rtIdx;
		regIdxT raIdx;
		regIdxT rbIdx;
		testErrStart = errCount;
		pcBase = addrT'($random(seed)) & ~addrT'(7);
		disp = 16'($random(seed)) | 16'h8000;
		ldDisp = 12'($random(seed)) | 12'h800;
		rtIdx = randReg();
		raIdx = randReg();
		rbIdx = randReg();
		// Top four bits above the load displacement must be ignored
		sendBundle(pcBase, immWord(LDX, rtIdx, raIdx, {4'hA, ldDisp}),
			splitWord(STX, raIdx, rbIdx, disp), 2);
		waitOut();
		checkField("pc[0]", pcBase, pc[0]);
		checkField("pc[1]", pcBase + 32'd8, pc[1]);
		checkWriter(0, rtIdx, raIdx, ldDisp[5:0], 0, 1, 1);
		checkKind(0, 1, 0, 0);
		checkField("imm[0]", {{52{ldDisp[11]}}, ldDisp}, imm[0]);
		checkKind(1, 0, 1, 0);
		checkField("laneValid[1]", 1, laneValid[1]);
		checkField("rfwr[1]", 0, rfwr[1]);
		checkField("rt[1]", 0, rt[1]);
		checkField("needRb[1]", 1, needRb[1]);
		checkField("imm[1]", {{48{disp[15]}}, disp}, imm[1]);
		disp = 16'($random(seed)) & 16'h7FFF;
		sendBundle(pcBase + 32'd64, splitWord(BLT, raIdx, rbIdx, disp), '0, 1);
		waitOut();
		checkKind(0, 0, 0, 1);
		checkField("rt[0]", 0, rt[0]);
		checkField("rfwr[0]", 0, rfwr[0]);
		checkField("needRb[0]", 1, needRb[0]);
		checkField("isSigned[0]", 1, isSigned[0]);
		checkField("imm[0]", {48'h0, disp}, imm[0]);
		jalDisp = 26'($random(seed)) | 26'h200_0000;
		link = 2'($random(seed));
		sendBundle(pcBase + 32'd128, {jalDisp, link, 8'(JAL)}, '0, 1);
		waitOut();
		checkKind(0, 0, 0, 1);
		checkField("needRa[0]", 0, needRa[0]);
		checkField("rfwr[0]", 1, rfwr[0]);
		checkField("rt[0]", {4'b0, link}, rt[0]);
		checkField("imm[0]", {{38{jalDisp[25]}}, jalDisp}, imm[0]);
		checkField("pc[0]", pcBase + 32'd128, pc[0]);
		finishTest("memory and control");
	endtask

	task automatic testHazard();
		testErrStart = errCount;
		sendBundle(32'h3000, regWord(R2, ADD, 6'd5, 6'd1, 6'd2),
			regWord(R2, SUB, 6'd6, 6'd5, 6'd3), 2);
		waitOut();
		checkField("hazard", 2'b10, hazard);
		// r0 is never a real destination
		sendBundle(32'h3010, regWord(R2, ADD, 6'd0, 6'd1, 6'd2),
			regWord(R2, ADD, 6'd6, 6'd0, 6'd0), 2);
		waitOut();
		checkField("hazard", 2'b00, hazard);
		// ADDI has r7 in its Rb field but does not read it
		sendBundle(32'h3020, regWord(R2, ADD, 6'd7, 6'd1, 6'd2),
			immWord(ADDI, 6'd8, 6'd3, 16'h0007), 2);
		waitOut();
		checkField("hazard", 2'b00, hazard);
		checkField("laneValid", 2'b11, laneValid);
		finishTest("hazard");
	endtask

	task automatic testBundleCut();
		testErrStart = errCount;
		sendBundle(32'h4000, splitWord(BEQ, 6'd1, 6'd2, 16'h0040),
			regWord(R2, ADD, 6'd3, 6'd4, 6'd5), 2);
		waitOut();
		checkField("laneValid", 2'b01, laneValid);
		checkField("illegalValid", 0, illegalValid);
		sendBundle(32'h4010, regWord(R2, ADD, 6'd3, 6'd4, 6'd5),
			regWord(R2, ADD, 6'd6, 6'd7, 6'd8), 1);
		waitOut();
		checkField("laneValid", 2'b01, laneValid);
		// An unknown op in a slot that is not filled is never reported
		sendBundle(32'h4020, '0, 36'h0_0000_0003, 0);
		waitOut();
		checkField("laneValid", 2'b00, laneValid);
		checkField("illegalValid", 0, illegalValid);
		sendBundle(32'h4030, 36'(NOP), 36'(BRK), 2);
		waitOut();
		checkField("laneValid", 2'b11, laneValid);
		checkField("ui", 2'b00, ui);
		finishTest("bundle cut");
	endtask

	task automatic testIllegal();
		testErrStart = errCount;
		sendBundle(32'h5000, regWord(R2, ADD, 6'd3, 6'd4, 6'd5), 36'h0_0000_0003, 2);
		waitOut();
		checkField("illegalValid", 1, illegalValid);
		checkField("illegalPc", 32'h5008, illegalPc);
		checkField("laneValid", 2'b01, laneValid);
		checkField("ui", 2'b10, ui);
		sendBundle(32'h5100, regWord(R2, 6'h3F, 6'd3, 6'd4, 6'd5),
			regWord(R2, ADD, 6'd6, 6'd7, 6'd8), 2);
		waitOut();
		checkField("illegalValid", 1, illegalValid);
		checkField("illegalPc", 32'h5100, illegalPc);
		checkField("laneValid", 2'b00, laneValid);
		checkField("ui", 2'b01, ui);
		finishTest("illegal instruction");
	endtask

	initial begin
		bundleValid = 1'b0;
		bundlePc = '0;
		bundleWords = '0;
		bundleCount = '0;
		wait (rstN === 1'b1);
		@(posedge clk);
		#1;
		testRegOps();
		testImmediates();
		testMemControl();
		testHazard();
		testBundleCut();
		testIllegal();
		$display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
		if (failCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
common/decodePkg.sv
decode/fetchSplitter.sv
decode/laneDecoder.sv
decode/bundleCollector.sv
rtl/decodeStage.sv
bench/clockGen.sv
bench/decodeStageTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module decodeStageTb -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
